// File: compile.f
verilog/mipsPkg.sv
verilog/mipsDecode.sv
verilog/mipsExecute.sv
verilog/mipsWriteback.sv
verilog/mipsCore.sv
verification/mipsCore_asserts.sv
verification/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mipsCore

sources:
  - verilog/mipsPkg.sv
  - verilog/mipsDecode.sv
  - verilog/mipsExecute.sv
  - verilog/mipsWriteback.sv
  - verilog/mipsCore.sv
  - target: simulation
    files:
      - verification/mipsCore_asserts.sv
      - verification/mipsCoreTb.sv

// File: verification/mipsCoreTb.sv
`timescale 1ns/1ns

module mipsCoreTb import mipsPkg::*; ();

    localparam int CLK_PERIOD = 100;
    // seed, alu, shift, imm, chains, dropped, reset
    localparam int TOTAL_SLOTS = 62 + 40 + 23 + 32 + 28 + 18 + 12;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    word_t       instr;
    logic        wbValid;
    regAddr_t    wbDest;
    word_t       wbData;
    logic [31:0] lfsrState = 32'h41ee_a333;
    funct_t      aluFuncts [10] = '{FT_ADD, FT_ADDU, FT_SUB, FT_SUBU, FT_AND,
                                    FT_OR, FT_XOR, FT_NOR, FT_SLT, FT_SLTU};

    mipsCore dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbDest     (wbDest),
        .wbData     (wbData)
    );

    bind mipsCore mipsCoreAsserts uChecker (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbDest     (wbDest),
        .wbData     (wbData)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t randBits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic word_t highReg();
        return 4 + randBits(5) % 28;  // keeps r2 and r3 intact
    endfunction

    function automatic word_t chainReg();
        return 1 + randBits(2) % 3;
    endfunction

    function automatic word_t rType(input funct_t f, input word_t rs, input word_t rt,
                                    input word_t rd, input word_t sa);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], f};
    endfunction

    function automatic word_t iType(input opcode_t op, input word_t rs, input word_t rt,
                                    input word_t imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic issue(input word_t ins);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= ins;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instrValid <= 1'b0;
            instr      <= randBits(32);  // ignored by the core
        end
    endtask

    task automatic seedRegisters();
        for (int r = 1; r < NUM_REGS; r++) begin
            issue(iType(OP_LUI, 0, r, randBits(16)));
            issue(iType(OP_ORI, r, r, randBits(16)));
        end
    endtask

    task automatic aluOps();
        foreach (aluFuncts[i]) begin
            repeat (4) begin
                issue(rType(aluFuncts[i], randBits(5), randBits(5), randBits(5), 0));
            end
        end
    endtask

    task automatic shifts();
        funct_t fixed [3] = '{FT_SLL, FT_SRL, FT_SRA};
        funct_t vary [3]  = '{FT_SLLV, FT_SRLV, FT_SRAV};
        word_t  amts [4]  = '{0, 31, randBits(5), randBits(5)};
        foreach (fixed[i]) begin
            foreach (amts[j]) begin
                issue(rType(fixed[i], 0, randBits(5), highReg(), amts[j]));
            end
        end
        issue(iType(OP_ADDIU, 0, 2, 0));
        issue(iType(OP_ADDIU, 0, 3, 31));
        foreach (vary[i]) begin
            issue(rType(vary[i], 2, randBits(5), highReg(), 0));
            issue(rType(vary[i], 3, randBits(5), highReg(), 0));
            issue(rType(vary[i], randBits(5), randBits(5), highReg(), 0));
        end
    endtask

    task automatic immediateOps();
        opcode_t ops [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                             OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        foreach (ops[i]) begin
            repeat (4) begin
                issue(iType(ops[i], randBits(5), randBits(5), randBits(16)));
            end
        end
    endtask

    // three registers only, so most instructions depend on the last two
    task automatic dependentChains();
        for (int i = 0; i < 24; i++) begin
            if (randBits(1) == 0) begin
                issue(rType(aluFuncts[randBits(4) % 10], chainReg(), chainReg(), chainReg(), 0));
            end else begin
                issue(iType(OP_ADDIU, chainReg(), chainReg(), randBits(16)));
            end
            if (i % 5 == 4) begin
                idle(1);
            end
        end
    endtask

    task automatic droppedOps();
        issue(iType(6'h04, randBits(5), randBits(5), randBits(16)));  // beq
        issue(iType(6'h23, randBits(5), randBits(5), randBits(16)));  // lw
        issue(iType(6'h2b, randBits(5), randBits(5), randBits(16)));  // sw
        issue(iType(6'h02, randBits(5), randBits(5), randBits(16)));  // j
        issue(rType(6'h18, randBits(5), randBits(5), highReg(), 0));  // mult
        issue(rType(6'h01, randBits(5), randBits(5), highReg(), 0));
        issue(rType(FT_ADDU, randBits(5), randBits(5), 0, 0));
        issue(iType(OP_ORI, randBits(5), 0, randBits(16)));
        issue(rType(FT_OR, 0, 0, highReg(), 0));
        issue(iType(OP_ADDIU, 0, highReg(), randBits(16)));
        idle(8);
    endtask

    task automatic resetInFlight();
        issue(iType(OP_ADDIU, 0, 7, randBits(16)));
        issue(rType(FT_ADDU, 7, 7, 8, 0));
        @(posedge clk);
        rstN       <= 1'b0;  // both still in the pipeline
        instrValid <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        issue(rType(FT_OR, 7, 8, 9, 0));
        issue(rType(FT_ADDU, 8, 0, 10, 0));
        idle(4);
    endtask

    task automatic finishRun(input int timeouts);
        int fails;
        int missing;
        fails   = dut.uChecker.failCount;
        missing = dut.uChecker.expCount - dut.uChecker.seenCount;
        if (missing != 0) begin
            $display("write-back count wrong: %0d expected but %0d seen",
                     dut.uChecker.expCount, dut.uChecker.seenCount);
        end
        $display("assertion failures %0d, timeouts %0d, missing write-backs %0d",
                 fails, timeouts, missing);
        if (fails == 0 && timeouts == 0 && missing == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #((TOTAL_SLOTS + 20) * CLK_PERIOD);
        $display("watchdog expired at %0t before the stimulus completed", $time);
        finishRun(1);
    end

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        seedRegisters();
        aluOps();
        shifts();
        immediateOps();
        dependentChains();
        droppedOps();
        resetInFlight();
        @(negedge clk);
        finishRun(0);
    end

endmodule

// File: verification/mipsCore_asserts.sv
`timescale 1ns/1ns

module mipsCoreAsserts import mipsPkg::*; (
    input logic     clk,
    input logic     rstN,
    input logic     instrValid,
    input word_t    instr,
    input logic     wbValid,
    input regAddr_t wbDest,
    input word_t    wbData
);

    word_t     shadow [NUM_REGS];
    wbResult_t exp1;  // sampled at the last edge
    wbResult_t exp2;  // due on the outputs now
    int        failCount = 0;
    int        expCount  = 0;
    int        seenCount = 0;

    // in-order ISA result against the shadow registers
    function automatic wbResult_t predict(input word_t ins);
        wbResult_t r;
        word_t     a;
        word_t     b;
        word_t     simm;
        shamt_t    sa;
        a       = shadow[ins[25:21]];
        b       = shadow[ins[20:16]];
        simm    = {{16{ins[15]}}, ins[15:0]};
        sa      = ins[10:6];
        r.valid = 1'b1;
        r.dest  = ins[20:16];
        r.data  = '0;
        case (opcode_t'(ins[31:26]))
            OP_SPECIAL: begin
                r.dest = ins[15:11];
                case (funct_t'(ins[5:0]))
                    FT_ADD, FT_ADDU: r.data = a + b;
                    FT_SUB, FT_SUBU: r.data = a - b;
                    FT_AND:  r.data = a & b;
                    FT_OR:   r.data = a | b;
                    FT_XOR:  r.data = a ^ b;
                    FT_NOR:  r.data = ~(a | b);
                    FT_SLT:  r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FT_SLTU: r.data = (a < b) ? 32'd1 : 32'd0;
                    FT_SLL:  r.data = b << sa;
                    FT_SRL:  r.data = b >> sa;
                    FT_SRA:  r.data = $signed(b) >>> sa;
                    FT_SLLV: r.data = b << a[4:0];
                    FT_SRLV: r.data = b >> a[4:0];
                    FT_SRAV: r.data = $signed(b) >>> a[4:0];
                    default: r.valid = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU: r.data = a + simm;
            OP_SLTI:  r.data = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            OP_SLTIU: r.data = (a < simm) ? 32'd1 : 32'd0;
            OP_ANDI:  r.data = a & {16'h0000, ins[15:0]};
            OP_ORI:   r.data = a | {16'h0000, ins[15:0]};
            OP_XORI:  r.data = a ^ {16'h0000, ins[15:0]};
            OP_LUI:   r.data = {ins[15:0], 16'h0000};
            default:  r.valid = 1'b0;
        endcase
        if (r.dest == '0) begin
            r.valid = 1'b0;  // r0 is never written
        end
        return r;
    endfunction

    always @(posedge clk) begin
        wbResult_t pred;
        pred = instrValid ? predict(instr) : '0;
        if (!rstN) begin
            foreach (shadow[i]) begin
                shadow[i] <= '0;
            end
            exp1 <= '0;
            exp2 <= '0;
        end else begin
            if (pred.valid) begin
                shadow[pred.dest] <= pred.data;
            end
            exp1      <= pred;
            exp2      <= exp1;
            expCount  <= expCount + int'(exp2.valid);
            seenCount <= seenCount + int'(wbValid);
        end
    end

    validMatch: assert property (@(posedge clk) disable iff (!rstN) wbValid == exp2.valid)
        else begin
            failCount++;
            $error("ERROR %0t wbValid expected %b actual %b",
                   $time, $sampled(exp2.valid), $sampled(wbValid));
        end

    destMatch: assert property (@(posedge clk) disable iff (!rstN)
            wbValid && exp2.valid |-> wbDest == exp2.dest)
        else begin
            failCount++;
            $error("ERROR %0t wbDest expected %0d actual %0d",
                   $time, $sampled(exp2.dest), $sampled(wbDest));
        end

    dataMatch: assert property (@(posedge clk) disable iff (!rstN)
            wbValid && exp2.valid |-> wbData == exp2.data)
        else begin
            failCount++;
            $error("ERROR %0t wbData expected %h actual %h",
                   $time, $sampled(exp2.data), $sampled(wbData));
        end

    resetClears: assert property (@(posedge clk) !rstN |=> !wbValid)
        else begin
            failCount++;
            $error("ERROR %0t wbValid expected 0 actual %b", $time, $sampled(wbValid));
        end

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/1ns

module mipsCore import mipsPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     instrValid,
    input  word_t    instr,
    output logic     wbValid,
    output regAddr_t wbDest,
    output word_t    wbData
);

    regAddr_t  rsAddr;
    regAddr_t  rtAddr;
    word_t     rsData;
    word_t     rtData;
    decoded_t  decoded;
    wbResult_t exFwd;
    wbResult_t wbResult;

    mipsDecode uDecode (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rsData     (rsData),
        .rtData     (rtData),
        .exFwd      (exFwd),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .decoded    (decoded)
    );

    mipsExecute uExecute (
        .clk      (clk),
        .rstN     (rstN),
        .decoded  (decoded),
        .exFwd    (exFwd),
        .wbResult (wbResult)
    );

    mipsWriteback uWriteback (
        .clk      (clk),
        .rstN     (rstN),
        .wbResult (wbResult),
        .rsAddr   (rsAddr),
        .rtAddr   (rtAddr),
        .rsData   (rsData),
        .rtData   (rtData)
    );

    assign wbValid = wbResult.valid;
    assign wbDest  = wbResult.dest;
    assign wbData  = wbResult.data;

endmodule

// File: verilog/mipsWriteback.sv
`timescale 1ns/1ns

module mipsWriteback import mipsPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  wbResult_t wbResult,
    input  regAddr_t  rsAddr,
    input  regAddr_t  rtAddr,
    output word_t     rsData,
    output word_t     rtData
);

    word_t regs [NUM_REGS];

    function automatic word_t readPort(input regAddr_t addr);
        if (addr == '0) begin
            return '0;  // r0 hardwired
        end else if (wbResult.valid && wbResult.dest == addr) begin
            return wbResult.data;  // write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbResult.valid && wbResult.dest != '0) begin
            regs[wbResult.dest] <= wbResult.data;
        end
    end

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

endmodule

// File: verilog/mipsExecute.sv
`timescale 1ns/1ns

module mipsExecute import mipsPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  decoded_t  decoded,
    output wbResult_t exFwd,
    output wbResult_t wbResult
);

    word_t  opA;
    word_t  opB;
    shamt_t shiftAmt;
    word_t  aluOut;

    assign opA      = decoded.opA;
    assign opB      = decoded.opB;
    assign shiftAmt = opB[4:0];  // low bits only

    always_comb begin
        case (decoded.aluOp)
            ALU_ADD: begin
                aluOut = opA + opB;
            end
            ALU_SUB: begin
                aluOut = opA - opB;
            end
            ALU_AND: begin
                aluOut = opA & opB;
            end
            ALU_OR: begin
                aluOut = opA | opB;
            end
            ALU_XOR: begin
                aluOut = opA ^ opB;
            end
            ALU_NOR: begin
                aluOut = ~(opA | opB);
            end
            ALU_SLT: begin
                aluOut = {31'd0, $signed(opA) < $signed(opB)};
            end
            ALU_SLTU: begin
                aluOut = {31'd0, opA < opB};
            end
            ALU_SLL: begin
                aluOut = opA << shiftAmt;
            end
            ALU_SRL: begin
                aluOut = opA >> shiftAmt;
            end
            ALU_SRA: begin
                aluOut = $signed(opA) >>> shiftAmt;
            end
            ALU_LUI: begin
                aluOut = {opB[15:0], 16'h0000};
            end
            default: begin
                aluOut = '0;
            end
        endcase
    end

    // same-cycle result, forwarded to decode
    assign exFwd.valid = decoded.valid;
    assign exFwd.dest  = decoded.dest;
    assign exFwd.data  = aluOut;

    always_ff @(posedge clk) begin
        wbResult <= exFwd;
        if (!rstN) begin
            wbResult.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/mipsDecode.sv
`timescale 1ns/1ns

module mipsDecode import mipsPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      instrValid,
    input  word_t     instr,
    input  word_t     rsData,
    input  word_t     rtData,
    input  wbResult_t exFwd,
    output regAddr_t  rsAddr,
    output regAddr_t  rtAddr,
    output decoded_t  decoded
);

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rd;
    shamt_t   shamt;
    imm_t     imm;

    logic     supported;
    aluOp_e   aluOp;
    logic     destRd;    // rd for special, rt otherwise
    logic     useImm;
    logic     useShamt;
    logic     isShift;
    logic     sext;

    regAddr_t dest;
    word_t    rsVal;
    word_t    rtVal;
    word_t    immExt;
    decoded_t decodedNext;

    assign opcode = instr[31:26];
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    always_comb begin
        supported = 1'b1;
        aluOp     = ALU_ADD;
        destRd    = (opcode == OP_SPECIAL);
        useImm    = (opcode != OP_SPECIAL);
        useShamt  = 1'b0;
        isShift   = 1'b0;
        sext      = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FT_ADD, FT_ADDU: aluOp = ALU_ADD;  // no overflow trap
                    FT_SUB, FT_SUBU: aluOp = ALU_SUB;
                    FT_AND:          aluOp = ALU_AND;
                    FT_OR:           aluOp = ALU_OR;
                    FT_XOR:          aluOp = ALU_XOR;
                    FT_NOR:          aluOp = ALU_NOR;
                    FT_SLT:          aluOp = ALU_SLT;
                    FT_SLTU:         aluOp = ALU_SLTU;
                    FT_SLL, FT_SLLV: aluOp = ALU_SLL;
                    FT_SRL, FT_SRLV: aluOp = ALU_SRL;
                    FT_SRA, FT_SRAV: aluOp = ALU_SRA;
                    default:         supported = 1'b0;
                endcase
                isShift  = (funct[5:3] == 3'b000);
                useShamt = (funct[5:2] == 4'b0000);  // sll, srl, sra
            end
            OP_ADDI, OP_ADDIU: begin
                aluOp = ALU_ADD;
                sext  = 1'b1;
            end
            OP_SLTI: begin
                aluOp = ALU_SLT;
                sext  = 1'b1;
            end
            OP_SLTIU: begin
                aluOp = ALU_SLTU;  // sign-extended, compared unsigned
                sext  = 1'b1;
            end
            OP_ANDI: aluOp = ALU_AND;
            OP_ORI:  aluOp = ALU_OR;
            OP_XORI: aluOp = ALU_XOR;
            OP_LUI:  aluOp = ALU_LUI;
            default: supported = 1'b0;
        endcase
    end

    assign immExt = sext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    assign dest   = destRd ? rd : rtAddr;

    // instruction one ahead is still in execute
    assign rsVal = (exFwd.valid && exFwd.dest == rsAddr && rsAddr != '0) ? exFwd.data : rsData;
    assign rtVal = (exFwd.valid && exFwd.dest == rtAddr && rtAddr != '0) ? exFwd.data : rtData;

    always_comb begin
        decodedNext.valid = instrValid && supported && (dest != '0);
        decodedNext.dest  = dest;
        decodedNext.aluOp = aluOp;
        decodedNext.opA   = isShift ? rtVal : rsVal;
        if (useImm) begin
            decodedNext.opB = immExt;
        end else if (useShamt) begin
            decodedNext.opB = {27'd0, shamt};
        end else if (isShift) begin
            decodedNext.opB = rsVal;  // variable shift amount
        end else begin
            decodedNext.opB = rtVal;
        end
    end

    always_ff @(posedge clk) begin
        decoded <= decodedNext;
        if (!rstN) begin
            decoded.valid <= 1'b0;
        end
    end

endmodule

// File: verilog/mipsPkg.sv
package mipsPkg;

    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int IMM_W    = 16;
    localparam int CODE_W   = 6;

    typedef logic [WORD_W-1:0] word_t;   // data or instruction word
    typedef logic [REG_W-1:0]  regAddr_t;
    typedef logic [REG_W-1:0]  shamt_t;
    typedef logic [IMM_W-1:0]  imm_t;
    typedef logic [CODE_W-1:0] opcode_t;
    typedef logic [CODE_W-1:0] funct_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;

    // special group function codes
    localparam funct_t FT_SLL  = 6'h00;
    localparam funct_t FT_SRL  = 6'h02;
    localparam funct_t FT_SRA  = 6'h03;
    localparam funct_t FT_SLLV = 6'h04;
    localparam funct_t FT_SRLV = 6'h06;
    localparam funct_t FT_SRAV = 6'h07;
    localparam funct_t FT_ADD  = 6'h20;
    localparam funct_t FT_ADDU = 6'h21;
    localparam funct_t FT_SUB  = 6'h22;
    localparam funct_t FT_SUBU = 6'h23;
    localparam funct_t FT_AND  = 6'h24;
    localparam funct_t FT_OR   = 6'h25;
    localparam funct_t FT_XOR  = 6'h26;
    localparam funct_t FT_NOR  = 6'h27;
    localparam funct_t FT_SLT  = 6'h2a;
    localparam funct_t FT_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } aluOp_e;

    // decode -> execute
    typedef struct packed {
        logic     valid;
        regAddr_t dest;
        aluOp_e   aluOp;
        word_t    opA;
        word_t    opB;
    } decoded_t;

    // one register write
    typedef struct packed {
        logic     valid;
        regAddr_t dest;
        word_t    data;
    } wbResult_t;

endpackage
